/* rtl/isa_pkg.sv */
`default_nettype none

package isa_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    localparam logic [reg_addr_w-1:0] ra_reg = 5'd1;  // link register written by bl

    // register fields
    localparam int rd_lsb = 0;
    localparam int rj_lsb = 5;
    localparam int rk_lsb = 10;

    // -------------------------------------------------------------------------
    // opcode prefixes, matched against inst[31:15], [31:22], [31:25], [31:26]
    // -------------------------------------------------------------------------
    localparam logic [16:0] op17_add  = 17'b0000_0000_0001_00000;
    localparam logic [16:0] op17_sub  = 17'b0000_0000_0001_00010;
    localparam logic [16:0] op17_slt  = 17'b0000_0000_0001_00100;
    localparam logic [16:0] op17_sltu = 17'b0000_0000_0001_00101;
    localparam logic [16:0] op17_and  = 17'b0000_0000_0001_01001;
    localparam logic [16:0] op17_or   = 17'b0000_0000_0001_01010;
    localparam logic [16:0] op17_xor  = 17'b0000_0000_0001_01011;
    localparam logic [16:0] op17_sll  = 17'b0000_0000_0001_01110;
    localparam logic [16:0] op17_srl  = 17'b0000_0000_0001_01111;
    localparam logic [16:0] op17_sra  = 17'b0000_0000_0001_10000;
    localparam logic [16:0] op17_slli = 17'b0000_0000_0100_00001;
    localparam logic [16:0] op17_srli = 17'b0000_0000_0100_01001;
    localparam logic [16:0] op17_srai = 17'b0000_0000_0100_10001;

    localparam logic [9:0] op10_slti  = 10'b00000_01000;
    localparam logic [9:0] op10_sltui = 10'b00000_01001;
    localparam logic [9:0] op10_addi  = 10'b00000_01010;
    localparam logic [9:0] op10_andi  = 10'b00000_01101;
    localparam logic [9:0] op10_ori   = 10'b00000_01110;
    localparam logic [9:0] op10_xori  = 10'b00000_01111;
    localparam logic [9:0] op10_ld_b  = 10'b00101_00000;
    localparam logic [9:0] op10_ld_h  = 10'b00101_00001;
    localparam logic [9:0] op10_ld_w  = 10'b00101_00010;
    localparam logic [9:0] op10_st_b  = 10'b00101_00100;
    localparam logic [9:0] op10_st_h  = 10'b00101_00101;
    localparam logic [9:0] op10_st_w  = 10'b00101_00110;
    localparam logic [9:0] op10_ld_bu = 10'b00101_01000;
    localparam logic [9:0] op10_ld_hu = 10'b00101_01001;

    localparam logic [6:0] op7_lu12i     = 7'b000_1010;
    localparam logic [6:0] op7_pcaddu12i = 7'b000_1110;

    localparam logic [5:0] op6_jirl = 6'b010_011;
    localparam logic [5:0] op6_b    = 6'b010_100;
    localparam logic [5:0] op6_bl   = 6'b010_101;
    localparam logic [5:0] op6_beq  = 6'b010_110;
    localparam logic [5:0] op6_bne  = 6'b010_111;
    localparam logic [5:0] op6_blt  = 6'b011_000;
    localparam logic [5:0] op6_bge  = 6'b011_001;
    localparam logic [5:0] op6_bltu = 6'b011_010;
    localparam logic [5:0] op6_bgeu = 6'b011_011;

    typedef enum logic [5:0] {
        inst_add, inst_addi, inst_sub, inst_slt, inst_slti, inst_sltu, inst_sltui,
        inst_and, inst_andi, inst_or, inst_ori, inst_xor, inst_xori,
        inst_sll, inst_slli, inst_srl, inst_srli, inst_sra, inst_srai,
        inst_lu12i, inst_pcaddu12i,
        inst_ld_w, inst_ld_h, inst_ld_b, inst_ld_hu, inst_ld_bu,
        inst_st_w, inst_st_h, inst_st_b,
        inst_beq, inst_bne, inst_blt, inst_bge, inst_bltu, inst_bgeu,
        inst_jirl, inst_b, inst_bl,
        inst_unknown                                    // keep last, bounds the range
    } inst_e;

endpackage

`default_nettype wire

/* rtl/ctrl_pkg.sv */
`default_nettype none

package ctrl_pkg;

    // values follow the execute stage ALU decode
    typedef enum logic [4:0] {
        alu_add   = 5'd0,
        alu_sub   = 5'd2,
        alu_slt   = 5'd4,
        alu_sltu  = 5'd5,
        alu_and   = 5'd9,
        alu_or    = 5'd10,
        alu_xor   = 5'd11,
        alu_sll   = 5'd14,
        alu_srl   = 5'd15,
        alu_sra   = 5'd16,
        alu_lui   = 5'd19,
        alu_pcadd = 5'd23
    } alu_op_e;

    typedef enum logic [3:0] {
        mem_none,
        ld_w, ld_h, ld_b, ld_hu, ld_bu,                 // 1..5
        st_w, st_h, st_b                                // 6..8
    } mem_acc_e;

    typedef enum logic [3:0] {
        br_none,
        br_eq, br_ne, br_lt, br_ge, br_ltu, br_geu,     // conditional, 1..6
        br_jirl, br_b, br_bl
    } br_type_e;

    typedef enum logic [1:0] {
        wd_pc4  = 2'd0,                                 // return address
        wd_alu  = 2'd1,
        wd_mem  = 2'd2,
        wd_none = 2'd3
    } wd_sel_e;

    typedef enum logic [2:0] {
        imm_zero,
        imm_si12,
        imm_ui12,
        imm_ui5,
        imm_si20_hi,
        imm_offs16,
        imm_offs26
    } imm_fmt_e;

endpackage

`default_nettype wire

/* rtl/inst_classifier.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_classifier (
    input  wire [isa_pkg::xlen-1:0] inst,
    output isa_pkg::inst_e          inst_id
);
    import isa_pkg::*;

    logic [16:0] op17;
    logic [9:0]  op10;
    logic [6:0]  op7;
    logic [5:0]  op6;

    assign op17 = inst[31:15];
    assign op10 = inst[31:22];
    assign op7  = inst[31:25];
    assign op6  = inst[31:26];

    // the prefix sets are disjoint, so later matches never overrule a real one
    always_comb begin
        inst_id = inst_unknown;
        case (op6)
            op6_beq:  inst_id = inst_beq;
            op6_bne:  inst_id = inst_bne;
            op6_blt:  inst_id = inst_blt;
            op6_bge:  inst_id = inst_bge;
            op6_bltu: inst_id = inst_bltu;
            op6_bgeu: inst_id = inst_bgeu;
            op6_jirl: inst_id = inst_jirl;
            op6_b:    inst_id = inst_b;
            op6_bl:   inst_id = inst_bl;
            default: ;
        endcase
        case (op7)
            op7_lu12i:     inst_id = inst_lu12i;
            op7_pcaddu12i: inst_id = inst_pcaddu12i;
            default: ;
        endcase
        case (op10)
            op10_addi:  inst_id = inst_addi;
            op10_slti:  inst_id = inst_slti;
            op10_sltui: inst_id = inst_sltui;
            op10_andi:  inst_id = inst_andi;
            op10_ori:   inst_id = inst_ori;
            op10_xori:  inst_id = inst_xori;
            op10_ld_w:  inst_id = inst_ld_w;
            op10_ld_h:  inst_id = inst_ld_h;
            op10_ld_b:  inst_id = inst_ld_b;
            op10_ld_hu: inst_id = inst_ld_hu;
            op10_ld_bu: inst_id = inst_ld_bu;
            op10_st_w:  inst_id = inst_st_w;
            op10_st_h:  inst_id = inst_st_h;
            op10_st_b:  inst_id = inst_st_b;
            default: ;
        endcase
        case (op17)
            op17_add:  inst_id = inst_add;
            op17_sub:  inst_id = inst_sub;
            op17_slt:  inst_id = inst_slt;
            op17_sltu: inst_id = inst_sltu;
            op17_and:  inst_id = inst_and;
            op17_or:   inst_id = inst_or;
            op17_xor:  inst_id = inst_xor;
            op17_sll:  inst_id = inst_sll;
            op17_srl:  inst_id = inst_srl;
            op17_sra:  inst_id = inst_sra;
            op17_slli: inst_id = inst_slli;
            op17_srli: inst_id = inst_srli;
            op17_srai: inst_id = inst_srai;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/imm_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module imm_gen (
    input  wire [isa_pkg::xlen-1:0] inst,
    input  wire ctrl_pkg::imm_fmt_e imm_fmt,
    output logic [isa_pkg::xlen-1:0] imm
);
    import ctrl_pkg::*;

    always_comb begin
        case (imm_fmt)
            imm_si12: begin
                imm = {{20{inst[21]}}, inst[21:10]};
            end
            imm_ui12: begin
                imm = {20'b0, inst[21:10]};               // andi, ori, xori
            end
            imm_ui5: begin
                imm = {27'b0, inst[14:10]};               // shift amount
            end
            imm_si20_hi: begin
                imm = {inst[24:5], 12'b0};
            end
            imm_offs16: begin
                imm = {{14{inst[25]}}, inst[25:10], 2'b0};
            end
            imm_offs26: begin
                // offs[25:16] sits in inst[9:0], so inst[9] carries the sign
                imm = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b0};
            end
            default: begin
                imm = '0;                                 // imm_zero
            end
        endcase
    end

endmodule

`default_nettype wire

/* rtl/ctrl_table.sv */
`timescale 1ns/1ps
`default_nettype none

module ctrl_table (
    input  wire isa_pkg::inst_e                 inst_id,
    input  wire [isa_pkg::xlen-1:0]             inst,
    output ctrl_pkg::alu_op_e                   alu_op,
    output ctrl_pkg::imm_fmt_e                  imm_fmt,
    output ctrl_pkg::mem_acc_e                  dmem_access,
    output ctrl_pkg::br_type_e                  br_type,
    output ctrl_pkg::wd_sel_e                   rf_wd_sel,
    output logic [isa_pkg::reg_addr_w-1:0]      rf_ra0,
    output logic [isa_pkg::reg_addr_w-1:0]      rf_ra1,
    output logic [isa_pkg::reg_addr_w-1:0]      rf_wa,
    output logic                                rf_we,
    output logic                                alu_src0_sel,
    output logic                                alu_src1_sel,
    output logic                                dmem_we
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] rj;
    logic [reg_addr_w-1:0] rk;

    assign rd = inst[rd_lsb +: reg_addr_w];
    assign rj = inst[rj_lsb +: reg_addr_w];
    assign rk = inst[rk_lsb +: reg_addr_w];

    always_comb begin
        case (inst_id)
            inst_sub:               alu_op = alu_sub;
            inst_slt, inst_slti:    alu_op = alu_slt;
            inst_sltu, inst_sltui:  alu_op = alu_sltu;
            inst_and, inst_andi:    alu_op = alu_and;
            inst_or, inst_ori:      alu_op = alu_or;
            inst_xor, inst_xori:    alu_op = alu_xor;
            inst_sll, inst_slli:    alu_op = alu_sll;
            inst_srl, inst_srli:    alu_op = alu_srl;
            inst_sra, inst_srai:    alu_op = alu_sra;
            inst_lu12i:             alu_op = alu_lui;
            inst_pcaddu12i:         alu_op = alu_pcadd;
            default:                alu_op = alu_add;   // add, addi, address calc, branches
        endcase
    end

    // memory access kind and branch kind
    always_comb begin
        dmem_access = mem_none;
        br_type     = br_none;
        case (inst_id)
            inst_ld_w:  dmem_access = ld_w;
            inst_ld_h:  dmem_access = ld_h;
            inst_ld_b:  dmem_access = ld_b;
            inst_ld_hu: dmem_access = ld_hu;
            inst_ld_bu: dmem_access = ld_bu;
            inst_st_w:  dmem_access = st_w;
            inst_st_h:  dmem_access = st_h;
            inst_st_b:  dmem_access = st_b;
            inst_beq:   br_type = br_eq;
            inst_bne:   br_type = br_ne;
            inst_blt:   br_type = br_lt;
            inst_bge:   br_type = br_ge;
            inst_bltu:  br_type = br_ltu;
            inst_bgeu:  br_type = br_geu;
            inst_jirl:  br_type = br_jirl;
            inst_b:     br_type = br_b;
            inst_bl:    br_type = br_bl;
            default: ;
        endcase
    end

    // -------------------------------------------------------------------------
    // per-class fields, defaults fit addi/slti/sltui and the loads
    // -------------------------------------------------------------------------
    always_comb begin
        rf_ra0       = rj;
        rf_ra1       = rk;
        rf_wa        = rd;
        rf_we        = 1'b1;
        alu_src0_sel = 1'b1;                            // rj
        alu_src1_sel = 1'b1;                            // immediate
        imm_fmt      = imm_si12;
        rf_wd_sel    = wd_alu;
        dmem_we      = 1'b0;
        case (inst_id)
            inst_add, inst_sub, inst_slt, inst_sltu, inst_and, inst_or, inst_xor,
            inst_sll, inst_srl, inst_sra: begin
                alu_src1_sel = 1'b0;                    // rk
                imm_fmt      = imm_zero;
            end
            inst_andi, inst_ori, inst_xori:  imm_fmt = imm_ui12;
            inst_slli, inst_srli, inst_srai: imm_fmt = imm_ui5;
            inst_lu12i, inst_pcaddu12i:      imm_fmt = imm_si20_hi;
            inst_ld_w, inst_ld_h, inst_ld_b, inst_ld_hu, inst_ld_bu: begin
                rf_wd_sel = wd_mem;
            end
            inst_st_w, inst_st_h, inst_st_b: begin
                rf_ra1    = rd;                         // store data
                rf_we     = 1'b0;
                rf_wd_sel = wd_mem;
                dmem_we   = 1'b1;
            end
            inst_beq, inst_bne, inst_blt, inst_bge, inst_bltu, inst_bgeu: begin
                rf_ra1       = rd;
                rf_we        = 1'b0;
                alu_src0_sel = 1'b0;                    // pc
                imm_fmt      = imm_offs16;
                rf_wd_sel    = wd_none;
            end
            inst_jirl: begin
                rf_ra1    = rd;
                imm_fmt   = imm_offs16;
                rf_wd_sel = wd_pc4;
            end
            inst_b, inst_bl: begin
                rf_ra1       = rd;
                rf_we        = inst_id == inst_bl;
                rf_wa        = (inst_id == inst_bl) ? ra_reg : rd;
                alu_src0_sel = 1'b0;
                imm_fmt      = imm_offs26;
                rf_wd_sel    = (inst_id == inst_bl) ? wd_pc4 : wd_none;
            end
            inst_unknown: begin
                rf_ra0       = '0;
                rf_ra1       = '0;
                rf_wa        = '0;
                rf_we        = 1'b0;
                alu_src1_sel = 1'b0;
                imm_fmt      = imm_zero;
                rf_wd_sel    = wd_none;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/id_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module id_stage (
    input  wire                             clk,
    input  wire                             arst_n,
    input  wire [isa_pkg::xlen-1:0]         inst,
    input  wire                             inst_valid,
    output logic                            dec_valid,
    output ctrl_pkg::alu_op_e               alu_op,
    output logic [isa_pkg::xlen-1:0]        imm,
    output ctrl_pkg::mem_acc_e              dmem_access,
    output logic [isa_pkg::reg_addr_w-1:0]  rf_ra0,
    output logic [isa_pkg::reg_addr_w-1:0]  rf_ra1,
    output logic [isa_pkg::reg_addr_w-1:0]  rf_wa,
    output logic                            rf_we,
    output ctrl_pkg::wd_sel_e               rf_wd_sel,
    output logic                            alu_src0_sel,
    output logic                            alu_src1_sel,
    output ctrl_pkg::br_type_e              br_type,
    output logic                            dmem_we
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    inst_e                 inst_id;
    alu_op_e               d_alu_op;
    imm_fmt_e              d_imm_fmt;
    mem_acc_e              d_dmem_access;
    br_type_e              d_br_type;
    wd_sel_e               d_rf_wd_sel;
    logic [reg_addr_w-1:0] d_rf_ra0;
    logic [reg_addr_w-1:0] d_rf_ra1;
    logic [reg_addr_w-1:0] d_rf_wa;
    logic                  d_rf_we;
    logic                  d_alu_src0_sel;
    logic                  d_alu_src1_sel;
    logic                  d_dmem_we;
    logic [xlen-1:0]       d_imm;

    inst_classifier u_classifier (
        .inst    (inst),
        .inst_id (inst_id)
    );

    ctrl_table u_ctrl (
        .inst_id      (inst_id),
        .inst         (inst),
        .alu_op       (d_alu_op),
        .imm_fmt      (d_imm_fmt),
        .dmem_access  (d_dmem_access),
        .br_type      (d_br_type),
        .rf_wd_sel    (d_rf_wd_sel),
        .rf_ra0       (d_rf_ra0),
        .rf_ra1       (d_rf_ra1),
        .rf_wa        (d_rf_wa),
        .rf_we        (d_rf_we),
        .alu_src0_sel (d_alu_src0_sel),
        .alu_src1_sel (d_alu_src1_sel),
        .dmem_we      (d_dmem_we)
    );

    imm_gen u_imm (
        .inst    (inst),
        .imm_fmt (d_imm_fmt),
        .imm     (d_imm)
    );

    // -------------------------------------------------------------------------
    // decode/execute boundary
    // -------------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_valid   <= 1'b0;
            rf_we       <= 1'b0;
            dmem_we     <= 1'b0;
            br_type     <= br_none;
            dmem_access <= mem_none;
        end else begin
            dec_valid   <= inst_valid;
            rf_we       <= inst_valid & d_rf_we;        // bubble never writes
            dmem_we     <= inst_valid & d_dmem_we;
            br_type     <= d_br_type;
            dmem_access <= d_dmem_access;
        end
    end

    always_ff @(posedge clk) begin
        alu_op       <= d_alu_op;
        imm          <= d_imm;
        rf_ra0       <= d_rf_ra0;
        rf_ra1       <= d_rf_ra1;
        rf_wa        <= d_rf_wa;
        rf_wd_sel    <= d_rf_wd_sel;
        alu_src0_sel <= d_alu_src0_sel;
        alu_src1_sel <= d_alu_src1_sel;
    end

    a_dmem_we_store: assert property (@(posedge clk) disable iff (!arst_n)
        dmem_we |-> dmem_access inside {st_w, st_h, st_b})
        else $error("id_stage: dmem_we with access kind %0d", dmem_access);

    a_rf_we_no_store_br: assert property (@(posedge clk) disable iff (!arst_n)
        rf_we |-> !(dmem_access inside {st_w, st_h, st_b})
               && !(br_type inside {[br_eq:br_geu]}))
        else $error("id_stage: rf_we with store or conditional branch");

endmodule

`default_nettype wire

/* tb/tb_id_checks.svh */
`ifndef TB_ID_CHECKS_SVH
`define TB_ID_CHECKS_SVH

typedef struct packed {
    alu_op_e         alu;
    logic [31:0]     imm;
    mem_acc_e        mem;
    br_type_e        br;
    wd_sel_e         wd;
    logic [4:0]      ra0;
    logic [4:0]      ra1;
    logic [4:0]      wa;
    logic            we;
    logic            src0;
    logic            src1;
    logic            dwe;
} dec_t;

dec_t want;
logic want_known = 1'b0;                                // first edge seen
logic want_valid;
logic want_ctl;                                         // br_type and dmem_access defined

// ---------------------------------------------------------------------------
// opcode prefixes and what each one selects
// ---------------------------------------------------------------------------
localparam logic [16:0] p17 [13] = '{op17_add, op17_sub, op17_slt, op17_sltu, op17_and,
    op17_or, op17_xor, op17_sll, op17_srl, op17_sra, op17_slli, op17_srli, op17_srai};
localparam alu_op_e alu17 [13] = '{alu_add, alu_sub, alu_slt, alu_sltu, alu_and,
    alu_or, alu_xor, alu_sll, alu_srl, alu_sra, alu_sll, alu_srl, alu_sra};
localparam logic [9:0] p10 [14] = '{op10_addi, op10_slti, op10_sltui, op10_andi, op10_ori,
    op10_xori, op10_ld_w, op10_ld_h, op10_ld_b, op10_ld_hu, op10_ld_bu,
    op10_st_w, op10_st_h, op10_st_b};
localparam alu_op_e alu10 [14] = '{alu_add, alu_slt, alu_sltu, alu_and, alu_or, alu_xor,
    alu_add, alu_add, alu_add, alu_add, alu_add, alu_add, alu_add, alu_add};
localparam mem_acc_e mem10 [14] = '{mem_none, mem_none, mem_none, mem_none, mem_none,
    mem_none, ld_w, ld_h, ld_b, ld_hu, ld_bu, st_w, st_h, st_b};
localparam logic [6:0] p7 [2] = '{op7_lu12i, op7_pcaddu12i};
localparam alu_op_e alu7 [2] = '{alu_lui, alu_pcadd};
localparam logic [5:0] p6 [9] = '{op6_beq, op6_bne, op6_blt, op6_bge, op6_bltu, op6_bgeu,
    op6_jirl, op6_b, op6_bl};
localparam br_type_e br6 [9] = '{br_eq, br_ne, br_lt, br_ge, br_ltu, br_geu,
    br_jirl, br_b, br_bl};

// class: 1 reg alu, 2 shift imm, 3 si12 alu, 4 ui12 logic, 5 load, 6 store,
// 7 upper imm, 8 cond branch, 9 jirl, 10 b, 11 bl
function automatic dec_t decode_ref(input logic [31:0] w);
    dec_t        d;
    int          cls;
    logic [25:0] offs;
    cls  = 0;
    offs = {w[9:0], w[25:10]};
    d.alu  = alu_add;                                   // unknown word defaults
    d.imm  = '0;
    d.mem  = mem_none;
    d.br   = br_none;
    d.wd   = wd_none;
    d.ra0  = '0;
    d.ra1  = '0;
    d.wa   = '0;
    d.we   = 1'b0;
    d.src0 = 1'b1;
    d.src1 = 1'b0;
    d.dwe  = 1'b0;
    for (int i = 0; i < 13; i++) begin
        if (w[31:15] == p17[i]) begin
            cls   = (i < 10) ? 1 : 2;
            d.alu = alu17[i];
        end
    end
    for (int i = 0; i < 14; i++) begin
        if (w[31:22] == p10[i]) begin
            cls   = (i < 3) ? 3 : (i < 6) ? 4 : (i < 11) ? 5 : 6;
            d.alu = alu10[i];
            d.mem = mem10[i];
        end
    end
    for (int i = 0; i < 2; i++) begin
        if (w[31:25] == p7[i]) begin
            cls   = 7;
            d.alu = alu7[i];
        end
    end
    for (int i = 0; i < 9; i++) begin
        if (w[31:26] == p6[i]) begin
            cls  = (i < 6) ? 8 : i + 3;
            d.br = br6[i];
        end
    end
    if (cls != 0) begin
        d.ra0  = w[9:5];
        d.ra1  = w[14:10];
        d.wa   = w[4:0];
        d.we   = 1'b1;
        d.src1 = 1'b1;
        d.wd   = wd_alu;
        d.imm  = {{20{w[21]}}, w[21:10]};
    end
    case (cls)
        1: begin
            d.src1 = 1'b0;
            d.imm  = '0;
        end
        2: d.imm = {27'b0, w[14:10]};
        4: d.imm = {20'b0, w[21:10]};
        5: d.wd = wd_mem;
        6: begin
            d.ra1 = w[4:0];                             // store data from rd
            d.we  = 1'b0;
            d.wd  = wd_mem;
            d.dwe = 1'b1;
        end
        7: d.imm = {w[24:5], 12'b0};
        8, 9: begin
            d.ra1 = w[4:0];
            d.imm = {{14{w[25]}}, w[25:10], 2'b00};
            d.we   = (cls == 9);
            d.src0 = (cls == 9);
            d.wd   = (cls == 9) ? wd_pc4 : wd_none;
        end
        10, 11: begin
            d.ra1  = w[4:0];
            d.src0 = 1'b0;
            d.imm  = {{4{offs[25]}}, offs, 2'b00};
            d.we   = (cls == 11);
            d.wa   = (cls == 11) ? ra_reg : w[4:0];
            d.wd   = (cls == 11) ? wd_pc4 : wd_none;
        end
        default: ;
    endcase
    return d;
endfunction

function automatic dec_t expect_after_edge(input logic [31:0] w, input logic v,
                                           input logic rst_n);
    dec_t d;
    d = decode_ref(w);
    if (!rst_n || !v) begin
        d.we  = 1'b0;                                   // bubble or reset never writes
        d.dwe = 1'b0;
    end
    if (!rst_n) begin
        d.br  = br_none;
        d.mem = mem_none;
    end
    return d;
endfunction

// ---------------------------------------------------------------------------
// output checks, half a cycle after the register updates
// ---------------------------------------------------------------------------
a_dec_valid: assert property (@(negedge clk) disable iff (!want_known) dec_valid == want_valid)
    else report_mismatch("dec_valid", 32'(want_valid), 32'(dec_valid));
a_rf_we: assert property (@(negedge clk) disable iff (!want_known) rf_we == want.we)
    else report_mismatch("rf_we", 32'(want.we), 32'(rf_we));
a_dmem_we: assert property (@(negedge clk) disable iff (!want_known) dmem_we == want.dwe)
    else report_mismatch("dmem_we", 32'(want.dwe), 32'(dmem_we));
a_br_type: assert property (@(negedge clk) disable iff (!want_known)
    want_ctl |-> br_type == want.br)
    else report_mismatch("br_type", 32'(want.br), 32'(br_type));
a_dmem_access: assert property (@(negedge clk) disable iff (!want_known)
    want_ctl |-> dmem_access == want.mem)
    else report_mismatch("dmem_access", 32'(want.mem), 32'(dmem_access));
a_alu_op: assert property (@(negedge clk) disable iff (!want_known)
    want_valid |-> alu_op == want.alu)
    else report_mismatch("alu_op", 32'(want.alu), 32'(alu_op));
a_imm: assert property (@(negedge clk) disable iff (!want_known)
    want_valid |-> imm == want.imm)
    else report_mismatch("imm", want.imm, imm);
a_rf_ra0: assert property (@(negedge clk) disable iff (!want_known)
    want_valid |-> rf_ra0 == want.ra0)
    else report_mismatch("rf_ra0", 32'(want.ra0), 32'(rf_ra0));
a_rf_ra1: assert property (@(negedge clk) disable iff (!want_known)
    want_valid |-> rf_ra1 == want.ra1)
    else report_mismatch("rf_ra1", 32'(want.ra1), 32'(rf_ra1));
a_rf_wa: assert property (@(negedge clk) disable iff (!want_known)
    want_valid |-> rf_wa == want.wa)
    else report_mismatch("rf_wa", 32'(want.wa), 32'(rf_wa));
a_rf_wd_sel: assert property (@(negedge clk) disable iff (!want_known)
    want_valid |-> rf_wd_sel == want.wd)
    else report_mismatch("rf_wd_sel", 32'(want.wd), 32'(rf_wd_sel));
a_alu_src0: assert property (@(negedge clk) disable iff (!want_known)
    want_valid |-> alu_src0_sel == want.src0)
    else report_mismatch("alu_src0_sel", 32'(want.src0), 32'(alu_src0_sel));
a_alu_src1: assert property (@(negedge clk) disable iff (!want_known)
    want_valid |-> alu_src1_sel == want.src1)
    else report_mismatch("alu_src1_sel", 32'(want.src1), 32'(alu_src1_sel));

`endif

/* tb/tb_id_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage;
    import isa_pkg::*;
    import ctrl_pkg::*;

    localparam int n_items   = 800;
    localparam int drain_max = 20;                      // cycles allowed for the last item

    logic                  clk;
    logic                  arst_n;
    logic [xlen-1:0]       inst;
    logic                  inst_valid;
    logic                  dec_valid;
    alu_op_e               alu_op;
    logic [xlen-1:0]       imm;
    mem_acc_e              dmem_access;
    logic [reg_addr_w-1:0] rf_ra0;
    logic [reg_addr_w-1:0] rf_ra1;
    logic [reg_addr_w-1:0] rf_wa;
    logic                  rf_we;
    wd_sel_e               rf_wd_sel;
    logic                  alu_src0_sel;
    logic                  alu_src1_sel;
    br_type_e              br_type;
    logic                  dmem_we;

    logic [15:0] lfsr;
    int          n_sent;
    int          n_checked = 0;

    task automatic report_mismatch(input string name, input logic [31:0] want_v,
                                   input logic [31:0] got_v);
        $display("FAIL t=%0t %s expected 0x%0h got 0x%0h", $time, name, want_v, got_v);
        $display("Done: errors found");
        $fatal(1, "%s mismatch", name);
    endtask

    `include "tb_id_checks.svh"

    id_stage uut (
        .clk          (clk),
        .arst_n       (arst_n),
        .inst         (inst),
        .inst_valid   (inst_valid),
        .dec_valid    (dec_valid),
        .alu_op       (alu_op),
        .imm          (imm),
        .dmem_access  (dmem_access),
        .rf_ra0       (rf_ra0),
        .rf_ra1       (rf_ra1),
        .rf_wa        (rf_wa),
        .rf_we        (rf_we),
        .rf_wd_sel    (rf_wd_sel),
        .alu_src0_sel (alu_src0_sel),
        .alu_src1_sel (alu_src1_sel),
        .br_type      (br_type),
        .dmem_we      (dmem_we)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // expected outputs for the edge just taken
    always @(posedge clk) begin
        want_known <= 1'b1;
        want_valid <= arst_n & inst_valid;
        want_ctl   <= !arst_n | inst_valid;
        want       <= expect_after_edge(inst, inst_valid, arst_n);
    end

    // decoded items leaving the DUT
    always @(negedge clk) begin
        if (want_known && dec_valid) begin
            n_checked <= n_checked + 1;
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    // random word with a known opcode prefix laid over it, or left as is
    task automatic make_inst(output logic [31:0] w);
        logic [31:0] r;
        logic [31:0] pick;
        int          k;
        draw_bits(32, r);
        draw_bits(6, pick);
        k = int'(pick % 32'd40);
        w = r;
        if (k < 13) begin
            w[31:15] = p17[k];
        end else if (k < 27) begin
            w[31:22] = p10[k - 13];
        end else if (k < 29) begin
            w[31:25] = p7[k - 27];
        end else if (k < 38) begin
            w[31:26] = p6[k - 29];
        end
    endtask

    initial begin
        logic [31:0] w;
        logic [31:0] vb;
        int          t;
        arst_n     = 1'b0;
        inst       = '0;
        inst_valid = 1'b0;
        lfsr       = 16'd27925;
        n_sent     = 0;
        repeat (3) @(posedge clk);
        #2;
        arst_n = 1'b1;
        for (int i = 0; i < n_items; i++) begin
            @(posedge clk);
            #2;
            make_inst(w);
            draw_bits(3, vb);
            inst       = w;
            inst_valid = (vb[2:0] != 3'd0);             // about one bubble in eight
            if (inst_valid) begin
                n_sent++;
            end
        end
        @(posedge clk);
        #2;
        inst_valid = 1'b0;
        t = 0;
        while (n_checked < n_sent && t < drain_max) begin
            @(negedge clk);
            t++;
        end
        if (n_checked < n_sent) begin
            $display("timeout: %0d decoded items seen out of %0d sent", n_checked, n_sent);
            $display("Done: errors found");
            $fatal(1, "timeout waiting for decoded items");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+tb
rtl/isa_pkg.sv
rtl/ctrl_pkg.sv
rtl/inst_classifier.sv
rtl/imm_gen.sv
rtl/ctrl_table.sv
rtl/id_stage.sv
tb/tb_id_stage.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the decode stage testbench, exit status follows the run
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module tb_id_stage \
    -f list.f -o tb_id_stage_sim &&
./obj_dir/tb_id_stage_sim || {
    echo "simulation failed"
    exit 1
}
